/* design/rle_pkg.sv */
// Run words need a length of 1 to 1023, and a 768 pixel black run has the same bits as the stop word
`default_nettype none

package rle_pkg;

    // Word and field widths
    localparam int INSTR_W = 18;           // One memory word
    localparam int RUN_W   = 10;           // Run length field
    localparam int ADDR_W  = 12;           // Up to 4096 words per image

    localparam logic [1:0] CTRL_STOP = 2'b11;   // Tag in bits 17:16 with zero arg

    // Run view [17:8] length and [7:0] RRRGGGBB
    typedef struct packed {
        logic [RUN_W-1:0] run_len;         // Pixels in this run
        logic [2:0]       red;
        logic [2:0]       green;
        logic [1:0]       blue;
    } rle_run_t;

    // Control view of the same bits
    typedef struct packed {
        logic [1:0]           tag;         // CTRL_STOP ends the image
        logic [INSTR_W-3:0]   arg;         // Zero for stop
    } rle_ctrl_t;

    // One word and two readings of it
    typedef union packed {
        rle_run_t  run;
        rle_ctrl_t ctrl;
    } rle_word_t;

endpackage

`default_nettype wire

/* design/vga_pkg.sv */
// Fixed 640x480 at 60 Hz timing for a 25 MHz class pixel clock and both syncs active low
`default_nettype none

package vga_pkg;

    // Horizontal timing in pixel clocks
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;   // 800

    // Vertical timing in lines
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;   // 525

    // Counter widths
    localparam int H_CNT_W = 10;           // Holds 0..799
    localparam int V_CNT_W = 10;           // Holds 0..524

    // Sync level during the pulse
    localparam logic SYNC_ACTIVE = 1'b0;

endpackage

`default_nettype wire

/* design/rle_fetch.sv */
// Needs a one-cycle synchronous-read memory and stays empty until the first frame_start
`default_nettype none

module rle_fetch (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         frame_start,   // Flush and reload from address 0
    input  wire                         advance,       // Head run fully consumed
    input  wire rle_pkg::rle_word_t     mem_data,      // Data for last cycle's address
    output logic [rle_pkg::ADDR_W-1:0]  mem_addr,
    output rle_pkg::rle_word_t          head,          // Oldest buffered word
    output logic                        head_valid
);

    rle_pkg::rle_word_t         buf0;       // Head entry
    rle_pkg::rle_word_t         buf1;       // Second entry
    logic [1:0]                 cnt;        // Entries held 0..2
    logic                       pend;       // A read returns this cycle
    logic                       run_en;     // Set by the first frame_start
    logic [rle_pkg::ADDR_W-1:0] rd_addr;    // Next sequential address
    logic [1:0]                 cnt_kept;   // Entries left after a pop
    logic [1:0]                 cnt_next;   // Entries at the end of this cycle
    logic                       issue;      // Read goes out this cycle

    assign cnt_kept = cnt - {1'b0, advance};
    assign cnt_next = cnt_kept + {1'b0, pend};

    // Only read when the word arriving next cycle has a slot
    // Keeps one read per cycle going while advances drain the head
    assign issue = frame_start | (run_en & (cnt_next < 2'd2));

    assign mem_addr = frame_start ? '0 : rd_addr;   // Address 0 leaves in the pulse cycle

    assign head       = buf0;
    assign head_valid = (cnt != 2'd0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt     <= 2'd0;
            pend    <= 1'b0;
            run_en  <= 1'b0;
            rd_addr <= '0;
        end else if (frame_start) begin
            cnt     <= 2'd0;                                 // Drop old words
            pend    <= 1'b1;                                 // Word 0 arrives next cycle
            run_en  <= 1'b1;
            rd_addr <= {{(rle_pkg::ADDR_W-1){1'b0}}, 1'b1};  // Then address 1
        end else begin
            cnt  <= cnt_next;
            pend <= issue;
            if (issue) begin
                rd_addr <= rd_addr + 1'b1;
            end
        end
    end

    // Shift on pop then land the returning word in the first free slot
    always_ff @(posedge clk) begin
        if (advance) begin
            buf0 <= buf1;
        end
        if (pend) begin
            if (cnt_kept == 2'd0) begin
                buf0 <= mem_data;      // Empty or just drained
            end else begin
                buf1 <= mem_data;
            end
        end
    end

    // Decoder must not pop an empty buffer
    a_adv_has_head: assert property (@(posedge clk) disable iff (!rst_n)
        advance |-> head_valid);

endmodule

`default_nettype wire

/* design/vga_timing.sv */
// Counts from the top-left active pixel after reset and delays the syncs one cycle for the decoder
`default_nettype none

module vga_timing (
    input  wire  clk,
    input  wire  rst_n,
    output logic pixel_req,     // High on every active pixel
    output logic frame_start,   // First cycle of the vsync line
    output logic hsync,
    output logic vsync
);

    logic [vga_pkg::H_CNT_W-1:0] h_cnt;
    logic [vga_pkg::V_CNT_W-1:0] v_cnt;
    logic h_end;           // Last clock of a line
    logic v_end;           // Last line of a frame
    logic active;          // Inside 640x480
    logic hs_on;           // Inside horizontal sync pulse
    logic vs_on;           // Inside vertical sync lines
    logic fs_hit;          // Start of the vsync line
    logic hsync_q;         // Syncs aligned with pixel_req
    logic vsync_q;

    assign h_end  = (h_cnt == vga_pkg::H_TOTAL - 1);
    assign v_end  = (v_cnt == vga_pkg::V_TOTAL - 1);
    assign active = (h_cnt < vga_pkg::H_ACTIVE) && (v_cnt < vga_pkg::V_ACTIVE);

    // Sync windows follow the front porch
    assign hs_on = (h_cnt >= vga_pkg::H_ACTIVE + vga_pkg::H_FRONT) &&
                   (h_cnt <  vga_pkg::H_ACTIVE + vga_pkg::H_FRONT + vga_pkg::H_SYNC);
    assign vs_on = (v_cnt >= vga_pkg::V_ACTIVE + vga_pkg::V_FRONT) &&
                   (v_cnt <  vga_pkg::V_ACTIVE + vga_pkg::V_FRONT + vga_pkg::V_SYNC);

    assign fs_hit = (h_cnt == '0) && (v_cnt == vga_pkg::V_ACTIVE + vga_pkg::V_FRONT);

    // Free running raster position
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_end) begin
            h_cnt <= '0;
            if (v_end) begin
                v_cnt <= '0;               // Wrap to top-left
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Stage 1 registers the position decode
    // Stage 2 delays the syncs to meet the registered colour
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pixel_req   <= 1'b0;
            frame_start <= 1'b0;
            hsync_q     <= ~vga_pkg::SYNC_ACTIVE;
            vsync_q     <= ~vga_pkg::SYNC_ACTIVE;
            hsync       <= ~vga_pkg::SYNC_ACTIVE;
            vsync       <= ~vga_pkg::SYNC_ACTIVE;
        end else begin
            pixel_req   <= active;
            frame_start <= fs_hit;
            hsync_q     <= hs_on ? vga_pkg::SYNC_ACTIVE : ~vga_pkg::SYNC_ACTIVE;
            vsync_q     <= vs_on ? vga_pkg::SYNC_ACTIVE : ~vga_pkg::SYNC_ACTIVE;
            hsync       <= hsync_q;
            vsync       <= vsync_q;
        end
    end

    // No pixel inside a sync pulse
    a_req_outside_sync: assert property (@(posedge clk) disable iff (!rst_n)
        pixel_req |-> (hsync_q != vga_pkg::SYNC_ACTIVE) && (vsync_q != vga_pkg::SYNC_ACTIVE));

endmodule

`default_nettype wire

/* design/rle_decoder.sv */
// Shows black without a valid head and treats only tag 2'b11 with zero arg as stop
`default_nettype none

module rle_decoder (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     pixel_req,      // Consume one pixel
    input  wire                     frame_start,    // Restart run count and clear stop
    input  wire rle_pkg::rle_word_t head,
    input  wire                     head_valid,
    output logic                    advance,        // Last pixel of head consumed
    output logic [2:0]              red,
    output logic [2:0]              green,
    output logic [1:0]              blue,
    output logic                    stop_detected
);

    logic [rle_pkg::RUN_W-1:0] px_cnt;   // Pixels already used from head
    logic is_stop;                       // Head is the stop word
    logic show;                          // Pixel taken from the head run
    logic last_px;                       // This pixel ends the run

    // Control view of head
    assign is_stop = head_valid && (head.ctrl.tag == rle_pkg::CTRL_STOP) &&
                     (head.ctrl.arg == '0);

    assign show = pixel_req && head_valid && !is_stop;

    // Run view of head
    assign last_px = (px_cnt + 1'b1 == head.run.run_len);
    assign advance = show && last_px;    // Fetch swaps head next cycle

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            px_cnt <= '0;
        end else if (frame_start || advance) begin
            px_cnt <= '0;                // Fresh run
        end else if (show) begin
            px_cnt <= px_cnt + 1'b1;
        end
    end

    // Colour for request in cycle t shows in t+1
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            red   <= 3'd0;
            green <= 3'd0;
            blue  <= 2'd0;
        end else if (show) begin
            red   <= head.run.red;
            green <= head.run.green;
            blue  <= head.run.blue;
        end else begin
            red   <= 3'd0;               // Blanking or empty or stopped
            green <= 3'd0;
            blue  <= 2'd0;
        end
    end

    // Sticky until the next reload
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stop_detected <= 1'b0;
        end else if (frame_start) begin
            stop_detected <= 1'b0;
        end else if (is_stop) begin
            stop_detected <= 1'b1;
        end
    end

    // Zero length would never raise advance and stall the image
    a_run_len_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        (head_valid && !is_stop) |-> (head.run.run_len != '0));

endmodule

`default_nettype wire

/* design/rle_vga_top.sv */
// Memory must answer mem_addr one cycle later and the image must fit in 4096 words
`default_nettype none

module rle_vga_top (
    input  wire                         clk,
    input  wire                         rst_n,
    output logic [rle_pkg::ADDR_W-1:0]  mem_addr,       // To instruction memory
    input  wire rle_pkg::rle_word_t     mem_data,       // Registered read data
    output logic                        hsync,
    output logic                        vsync,
    output logic [2:0]                  red,
    output logic [2:0]                  green,
    output logic [1:0]                  blue,
    output logic                        stop_detected   // Stop word reached this frame
);

    logic               pixel_req;      // Timing to decoder
    logic               frame_start;    // Reload pulse to fetch and decoder
    logic               advance;        // Decoder pops fetch
    rle_pkg::rle_word_t head;
    logic               head_valid;

    // Word stream from memory
    rle_fetch u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .advance     (advance),
        .mem_data    (mem_data),
        .mem_addr    (mem_addr),
        .head        (head),
        .head_valid  (head_valid)
    );

    // Raster and syncs
    vga_timing u_timing (
        .clk         (clk),
        .rst_n       (rst_n),
        .pixel_req   (pixel_req),
        .frame_start (frame_start),
        .hsync       (hsync),
        .vsync       (vsync)
    );

    // Runs to pixels
    rle_decoder u_decoder (
        .clk           (clk),
        .rst_n         (rst_n),
        .pixel_req     (pixel_req),
        .frame_start   (frame_start),
        .head          (head),
        .head_valid    (head_valid),
        .advance       (advance),
        .red           (red),
        .green         (green),
        .blue          (blue),
        .stop_detected (stop_detected)
    );

endmodule

`default_nettype wire

/* testbench/tb_rle_vga.sv */
// Runs about 1.25M clocks through two checked frames and needs the image to fit in 4096 words
`default_nettype none

module tb_rle_vga;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEED        = 32'h8e4e;
    localparam int TIMEOUT_CYC = 450000;        // Longer than one frame
    localparam int RESET_CYC   = 16;
    localparam int N_RAND      = 40;            // Random rows after the fixed ones
    localparam int MEM_DEPTH   = 1 << rle_pkg::ADDR_W;
    localparam int PIX_TOTAL   = vga_pkg::H_ACTIVE * vga_pkg::V_ACTIVE;
    localparam int FRAME_CYC   = vga_pkg::H_TOTAL * vga_pkg::V_TOTAL;
    localparam int HS_START    = vga_pkg::H_ACTIVE + vga_pkg::H_FRONT;
    localparam int VS_START    = vga_pkg::V_ACTIVE + vga_pkg::V_FRONT;

    // Test ids
    localparam int T_RESET = 0;
    localparam int T_SYNC  = 1;
    localparam int T_PIX   = 2;
    localparam int T_BLANK = 3;
    localparam int T_STOP  = 4;
    localparam int T_REP   = 5;
    localparam int N_TESTS = 6;

    logic                          clk = 1'b0;
    logic                          rst_n;
    logic [rle_pkg::ADDR_W-1:0]    mem_addr;
    logic [rle_pkg::INSTR_W-1:0]   mem_data;
    logic                          hsync;
    logic                          vsync;
    logic [2:0]                    red;
    logic [2:0]                    green;
    logic [1:0]                    blue;
    logic                          stop_detected;

    logic [rle_pkg::INSTR_W-1:0]   mem [0:MEM_DEPTH-1];
    logic [rle_pkg::ADDR_W-1:0]    addr_hold;            // Address latched one cycle back
    logic [7:0]                    exp_pix [0:PIX_TOTAL-1];
    logic [7:0]                    first_pix [0:PIX_TOTAL-1];  // Frame 1 capture
    int                            tbl_len[$];           // Run table, length column
    logic [7:0]                    tbl_col[$];           // Run table, RRRGGGBB column
    int                            stream_len;           // Pixels before stop
    int                            err_cnt [N_TESTS];
    int                            cyc = 0;              // Rising edges seen
    int                            last_fall = -1;       // Cycle of previous vsync fall
    logic                          last_vs = 1'b1;
    integer                        seed;

    rle_vga_top DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_addr      (mem_addr),
        .mem_data      (mem_data),
        .hsync         (hsync),
        .vsync         (vsync),
        .red           (red),
        .green         (green),
        .blue          (blue),
        .stop_detected (stop_detected)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // One cycle read latency, address taken on one falling edge and data out on the next
    always @(negedge clk) begin
        mem_data  <= mem[addr_hold];
        addr_hold <= mem_addr;
    end

    task automatic report_mismatch(input int test_id, input string sig,
                                   input logic [31:0] got, input logic [31:0] exp);
        $display("CHECK FAILED %s got 0x%0h expected 0x%0h at cycle %0d", sig, got, exp, cyc);
        err_cnt[test_id]++;
    endtask

    task automatic add_run(input int len, input logic [7:0] col);
        tbl_len.push_back(len);
        tbl_col.push_back(col);
    endtask

    // Table to memory words and to the expected pixel stream
    task automatic build_image();
        int i;
        int j;
        int p;
        int len;
        logic [7:0] col;
        add_run(1, 8'he0);            // Back to back single pixels
        add_run(1, 8'h1c);
        add_run(1, 8'h03);
        add_run(1, 8'hff);
        add_run(2, 8'h92);
        add_run(2, 8'h49);
        add_run(1023, 8'h6d);         // Longest run, wraps line 0
        add_run(400, 8'hb6);          // Starts at x=391 of line 1 and wraps
        for (i = 0; i < N_RAND; i++) begin
            len = ($random(seed) & 511) + 1;   // Under 768 so never the stop bits
            col = $random(seed) & 8'hff;
            add_run(len, col);
        end
        for (i = 0; i < MEM_DEPTH; i++) begin
            mem[i] = {6'h2a, i[11:0] ^ 12'hc35};   // Filler, never reaches head
        end
        for (i = 0; i < tbl_len.size(); i++) begin
            len    = tbl_len[i];
            mem[i] = {len[9:0], tbl_col[i]};
        end
        mem[tbl_len.size()] = {rle_pkg::CTRL_STOP, 16'h0000};
        p = 0;
        for (i = 0; i < tbl_len.size(); i++) begin
            for (j = 0; j < tbl_len[i]; j++) begin
                exp_pix[p] = tbl_col[i];
                p++;
            end
        end
        stream_len = p;
        for (; p < PIX_TOTAL; p++) begin
            exp_pix[p] = 8'h00;       // Black after stop
        end
    endtask

    // Leaves last_vs high so the walk sees the fall itself
    task automatic wait_vsync_fall(output logic found);
        int n;
        found = 1'b0;
        n = 0;
        while (!found && n < TIMEOUT_CYC) begin
            @(negedge clk);
            n++;
            if (last_vs === 1'b1 && vsync === 1'b0) begin
                found = 1'b1;
            end else begin
                if ({red, green, blue} !== 8'h00) report_mismatch(T_RESET, "{red,green,blue}",
                                                                  {red, green, blue}, 8'h00);
                if (stop_detected !== 1'b0) report_mismatch(T_RESET, "stop_detected",
                                                            stop_detected, 1'b0);
                last_vs = vsync;
            end
        end
    endtask

    // Pin position starts at (0, first vsync line)
    task automatic walk_frame(input int frame_no);
        int k;
        int h;
        int v;
        int p;
        int hs_low;
        int vs_low;
        logic [7:0] col;
        logic hs_exp;
        logic vs_exp;
        logic stop_arm;
        h = 0;
        v = VS_START;
        hs_low = 0;
        vs_low = 0;
        stop_arm = 1'b0;
        for (k = 0; k < FRAME_CYC; k++) begin
            if (k > 0) @(negedge clk);
            col = {red, green, blue};
            if (last_vs === 1'b1 && vsync === 1'b0) begin
                if (k != 0) begin
                    $display("vsync fell in the middle of frame %0d", frame_no);
                    err_cnt[T_SYNC]++;
                end
                if (last_fall >= 0 && cyc - last_fall != FRAME_CYC)
                    report_mismatch(T_SYNC, "vsync period", cyc - last_fall, FRAME_CYC);
                last_fall = cyc;
            end
            last_vs = vsync;
            // Reload reads address 0 in the pulse cycle then 1
            if (k == 0 && mem_addr !== 1)
                report_mismatch(T_REP, "mem_addr", mem_addr, 1);
            if (k == FRAME_CYC - 1 && mem_addr !== 0)
                report_mismatch(T_REP, "mem_addr", mem_addr, 0);
            hs_exp = (h >= HS_START && h < HS_START + vga_pkg::H_SYNC) ?
                     vga_pkg::SYNC_ACTIVE : ~vga_pkg::SYNC_ACTIVE;
            vs_exp = (v >= VS_START && v < VS_START + vga_pkg::V_SYNC) ?
                     vga_pkg::SYNC_ACTIVE : ~vga_pkg::SYNC_ACTIVE;
            if (hsync !== hs_exp) report_mismatch(T_SYNC, "hsync", hsync, hs_exp);
            if (vsync !== vs_exp) report_mismatch(T_SYNC, "vsync", vsync, vs_exp);
            if (hsync === vga_pkg::SYNC_ACTIVE) hs_low++;
            if (vsync === vga_pkg::SYNC_ACTIVE) vs_low++;
            if (stop_detected !== stop_arm) report_mismatch(T_STOP, "stop_detected",
                                                            stop_detected, stop_arm);
            if (h < vga_pkg::H_ACTIVE && v < vga_pkg::V_ACTIVE) begin
                p = v * vga_pkg::H_ACTIVE + h;   // Row-major pixel index
                if (col !== exp_pix[p]) report_mismatch(p < stream_len ? T_PIX : T_STOP,
                                                        "{red,green,blue}", col, exp_pix[p]);
                if (frame_no == 1) begin
                    first_pix[p] = col;
                end else if (col !== first_pix[p]) begin
                    report_mismatch(T_REP, "{red,green,blue} vs frame 1", col, first_pix[p]);
                end
                if (p == stream_len - 1) stop_arm = 1'b1;   // Stop level from next cycle
            end else if (col !== 8'h00) begin
                report_mismatch(T_BLANK, "{red,green,blue}", col, 8'h00);
            end
            h++;
            if (h == vga_pkg::H_TOTAL) begin
                h = 0;
                v = (v == vga_pkg::V_TOTAL - 1) ? 0 : v + 1;
            end
        end
        if (hs_low != vga_pkg::V_TOTAL * vga_pkg::H_SYNC)
            report_mismatch(T_SYNC, "hsync low cycles", hs_low, vga_pkg::V_TOTAL * vga_pkg::H_SYNC);
        if (vs_low != vga_pkg::V_SYNC * vga_pkg::H_TOTAL)
            report_mismatch(T_SYNC, "vsync low cycles", vs_low, vga_pkg::V_SYNC * vga_pkg::H_TOTAL);
    endtask

    task automatic print_result(input int test_id, input string name);
        if (err_cnt[test_id] == 0) $display("test %0d %s: passed", test_id + 1, name);
        else $display("test %0d %s: failed with %0d errors", test_id + 1, name, err_cnt[test_id]);
    endtask

    initial begin
        int i;
        int n_fail;
        int n_err;
        logic found;
        rst_n    = 1'b0;
        mem_data = '0;
        addr_hold = '0;
        seed     = SEED;
        for (i = 0; i < N_TESTS; i++) err_cnt[i] = 0;
        build_image();
        for (i = 0; i < RESET_CYC; i++) begin
            @(negedge clk);
            if (hsync !== 1'b1) report_mismatch(T_RESET, "hsync", hsync, 1'b1);
            if (vsync !== 1'b1) report_mismatch(T_RESET, "vsync", vsync, 1'b1);
            if ({red, green, blue} !== 8'h00) report_mismatch(T_RESET, "{red,green,blue}",
                                                              {red, green, blue}, 8'h00);
            if (stop_detected !== 1'b0) report_mismatch(T_RESET, "stop_detected",
                                                        stop_detected, 1'b0);
        end
        rst_n = 1'b1;
        wait_vsync_fall(found);
        if (!found) begin
            $display("Timeout: vsync did not fall within %0d cycles after reset", TIMEOUT_CYC);
            $display("FAIL: see errors above");
        end else begin
            print_result(T_RESET, "reset and idle frame");
            walk_frame(1);
            @(negedge clk);
            walk_frame(2);
            print_result(T_SYNC, "sync geometry");
            print_result(T_PIX, "active pixels");
            print_result(T_BLANK, "blanking");
            print_result(T_STOP, "stop");
            print_result(T_REP, "frame repeat");
            n_fail = 0;
            n_err  = 0;
            for (i = 0; i < N_TESTS; i++) begin
                if (err_cnt[i] != 0) n_fail++;
                n_err += err_cnt[i];
            end
            $display("tests %0d, passed %0d, failed %0d, errors %0d",
                     N_TESTS, N_TESTS - n_fail, n_fail, n_err);
            if (n_err == 0) begin
                $display("PASS: all tests");
            end else begin
                $display("FAIL: see errors above");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
design/rle_pkg.sv
design/vga_pkg.sv
design/rle_fetch.sv
design/vga_timing.sv
design/rle_decoder.sv
design/rle_vga_top.sv
testbench/tb_rle_vga.sv

/* Bender.yml */
# RLE image on 640x480 VGA, packages first
package:
  name: rle_vga

dependencies: {}

sources:
  # Packages
  - design/rle_pkg.sv
  - design/vga_pkg.sv
  # RTL
  - design/rle_fetch.sv
  - design/vga_timing.sv
  - design/rle_decoder.sv
  - design/rle_vga_top.sv
  # Testbench, top module tb_rle_vga
  - target: test
    files:
      - testbench/tb_rle_vga.sv
